// ==== Bender.yml ====
package:
  name: ctrlport_cdc

sources:
  - design/ctrlport_pkg.sv
  - design/handshake.sv
  - design/ctrlport_clk_cross.sv
  - design/ctrlport_timekeeper.sv
  - design/ctrlport_reg_bank.sv
  - design/ctrlport_cdc_top.sv
  - target: simulation
    files:
      - tb/tb_ctrlport_cdc.sv

// ==== ctrlport_cdc.f ====
design/ctrlport_pkg.sv
design/handshake.sv
design/ctrlport_clk_cross.sv
design/ctrlport_timekeeper.sv
design/ctrlport_reg_bank.sv
design/ctrlport_cdc_top.sv
tb/tb_ctrlport_cdc.sv

// ==== design/ctrlport_cdc_top.sv ====
// top level joining the clock crossing, the timekeeper and the endpoint register bank
`timescale 1ns/1ps

module ctrlport_cdc_top #(
  parameter int SYNC_STAGES = 2,   // at least 2
  parameter int NUM_REGS    = 16   // power of two, 2 to 256
) (
  input  logic                        reset,
  input  logic                        s_ctrlport_clk,
  input  logic                        m_ctrlport_clk,
  input  ctrlport_pkg::ctrlport_req_t  s_req,
  output ctrlport_pkg::ctrlport_resp_t s_resp,
  output ctrlport_pkg::ctrlport_time_t m_time_now  // m domain
);
  import ctrlport_pkg::*;

  ctrlport_req_t  m_req;     // request strobe in the m domain
  ctrlport_resp_t m_resp;    // response strobe in the m domain
  logic           m_rst;
  logic           arm;
  logic           due;
  ctrlport_time_t due_time;

  ctrlport_clk_cross #(.SYNC_STAGES(SYNC_STAGES)) ctrlport_clk_cross_inst (
    .reset         (reset),
    .s_ctrlport_clk(s_ctrlport_clk),
    .s_req         (s_req),
    .s_resp        (s_resp),
    .m_ctrlport_clk(m_ctrlport_clk),
    .m_req         (m_req),
    .m_resp        (m_resp),
    .m_rst         (m_rst)
  );

  ctrlport_timekeeper ctrlport_timekeeper_inst (
    .m_ctrlport_clk(m_ctrlport_clk),
    .m_rst         (m_rst),
    .arm           (arm),
    .due_time      (due_time),
    .time_now      (m_time_now),
    .due           (due)
  );

  ctrlport_reg_bank #(.NUM_REGS(NUM_REGS)) ctrlport_reg_bank_inst (
    .m_ctrlport_clk(m_ctrlport_clk),
    .m_rst         (m_rst),
    .m_req         (m_req),
    .due           (due),
    .time_now      (m_time_now),
    .m_resp        (m_resp),
    .arm           (arm),
    .due_time      (due_time)
  );

endmodule

// ==== design/ctrlport_clk_cross.sv ====
// control-port crossing between requester and endpoint clocks with reset synchronizers
`timescale 1ns/1ps

module ctrlport_clk_cross #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                        reset,
  // requester domain
  input  logic                        s_ctrlport_clk,
  input  ctrlport_pkg::ctrlport_req_t  s_req,
  output ctrlport_pkg::ctrlport_resp_t s_resp,
  // endpoint domain
  input  logic                        m_ctrlport_clk,
  output ctrlport_pkg::ctrlport_req_t  m_req,
  input  ctrlport_pkg::ctrlport_resp_t m_resp,
  output logic                        m_rst
);
  import ctrlport_pkg::*;

  logic [SYNC_STAGES-1:0] s_rst_sync;
  logic [SYNC_STAGES-1:0] m_rst_sync;
  logic                   s_rst;
  ctrlport_req_t          m_req_raw;   // held word, strobes not yet qualified
  logic                   m_req_valid;
  ctrlport_resp_t         s_resp_raw;
  logic                   s_resp_valid;

  // ----------------------------------------------------------
  // reset into each domain
  // ----------------------------------------------------------

  always_ff @(posedge s_ctrlport_clk) s_rst_sync <= {s_rst_sync[SYNC_STAGES-2:0], reset};
  always_ff @(posedge m_ctrlport_clk) m_rst_sync <= {m_rst_sync[SYNC_STAGES-2:0], reset};

  assign s_rst = s_rst_sync[SYNC_STAGES-1];
  assign m_rst = m_rst_sync[SYNC_STAGES-1];

  // ----------------------------------------------------------
  // request, s to m
  // ----------------------------------------------------------

  // busy ignored, one transaction in flight at a time
  handshake #(.WIDTH($bits(ctrlport_req_t)), .SYNC_STAGES(SYNC_STAGES)) req_handshake_inst (
    .clk_a  (s_ctrlport_clk),
    .rst_a  (s_rst),
    .valid_a((s_req.wr | s_req.rd) & ~s_rst),
    .data_a (s_req),
    .busy_a (),
    .clk_b  (m_ctrlport_clk),
    .valid_b(m_req_valid),
    .data_b (m_req_raw)
  );

  always_comb begin
    m_req    = m_req_raw;
    m_req.wr = m_req_raw.wr & m_req_valid & ~m_rst;  // strobe only on arrival
    m_req.rd = m_req_raw.rd & m_req_valid & ~m_rst;
  end

  // ----------------------------------------------------------
  // response, m to s
  // ----------------------------------------------------------

  handshake #(.WIDTH($bits(ctrlport_resp_t)), .SYNC_STAGES(SYNC_STAGES)) resp_handshake_inst (
    .clk_a  (m_ctrlport_clk),
    .rst_a  (m_rst),
    .valid_a(m_resp.ack & ~m_rst),
    .data_a (m_resp),
    .busy_a (),
    .clk_b  (s_ctrlport_clk),
    .valid_b(s_resp_valid),
    .data_b (s_resp_raw)
  );

  always_comb begin
    s_resp     = s_resp_raw;
    s_resp.ack = s_resp_raw.ack & s_resp_valid & ~s_rst;
  end

endmodule

// ==== design/ctrlport_pkg.sv ====
// control-port request, response and status types shared across both clock domains
package ctrlport_pkg;

  // ----------------------------------------------------------
  // status codes
  // ----------------------------------------------------------

  typedef enum logic [1:0] {
    sts_okay    = 2'd0,  // transaction done
    sts_cmderr  = 2'd1,  // bad address, or wr and rd together
    sts_tserr   = 2'd2,  // timed request arrived after its time
    sts_warning = 2'd3   // reserved, never produced
  } ctrlport_status_t;

  // 64-bit time, counted in endpoint clock cycles
  typedef logic [63:0] ctrlport_time_t;

  // ----------------------------------------------------------
  // request word, 159 bits, msb first
  // ----------------------------------------------------------

  typedef struct packed {
    logic           wr;          // write strobe
    logic           rd;          // read strobe
    logic [19:0]    addr;        // byte address
    logic [9:0]     portid;      // carried, not decoded
    logic [15:0]    rem_epid;    // carried, not decoded
    logic [9:0]     rem_portid;  // carried, not decoded
    logic [31:0]    data;        // write data
    logic [3:0]     byte_en;     // one bit per byte of data
    logic           has_time;    // execute at timestamp
    ctrlport_time_t timestamp;   // requested execution time
  } ctrlport_req_t;

  // ----------------------------------------------------------
  // response word, 35 bits, msb first
  // ----------------------------------------------------------

  typedef struct packed {
    logic             ack;     // single-cycle response strobe
    ctrlport_status_t status;  // outcome of the request
    logic [31:0]      data;    // read data, zero for writes and errors
  } ctrlport_resp_t;

endpackage

// ==== design/ctrlport_reg_bank.sv ====
// endpoint register bank, byte-enable writes, reads, address check and timed execution
`timescale 1ns/1ps

module ctrlport_reg_bank #(
  parameter int NUM_REGS = 16
) (
  input  logic                        m_ctrlport_clk,
  input  logic                        m_rst,
  input  ctrlport_pkg::ctrlport_req_t  m_req,
  input  logic                        due,
  input  ctrlport_pkg::ctrlport_time_t time_now,
  output ctrlport_pkg::ctrlport_resp_t m_resp,
  output logic                        arm,
  output ctrlport_pkg::ctrlport_time_t due_time
);
  import ctrlport_pkg::*;

  localparam int AW = $clog2(NUM_REGS);  // word index width

  logic [31:0]      regs [NUM_REGS];
  logic             pend;       // timed request waiting for due
  ctrlport_req_t    pend_req;   // the waiting request
  ctrlport_req_t    exec_req;   // request executed this cycle
  logic             strobe;
  logic             addr_ok;
  logic             late;
  logic             early;
  logic             fire;       // held request reaches its time
  logic             reject;
  logic             exec_now;
  ctrlport_status_t rej_status;
  logic [AW-1:0]    idx;

  // ----------------------------------------------------------
  // decode of the arriving request
  // ----------------------------------------------------------

  assign strobe  = m_req.wr | m_req.rd;
  assign addr_ok = (m_req.addr[19:2+AW] == '0);  // word index below NUM_REGS
  assign late    = m_req.has_time && (m_req.timestamp < time_now);
  assign early   = m_req.has_time && (m_req.timestamp > time_now);
  assign fire    = pend & due;

  always_comb begin
    reject     = 1'b0;
    rej_status = sts_okay;
    if (strobe) begin
      if ((m_req.wr & m_req.rd) | ~addr_ok) begin
        reject     = 1'b1;
        rej_status = sts_cmderr;
      end else if (late) begin
        reject     = 1'b1;
        rej_status = sts_tserr;  // not executed
      end
    end
  end

  // only one request is in flight, so fire and strobe never meet
  assign exec_now = fire | (strobe & ~reject & ~early);
  assign exec_req = fire ? pend_req : m_req;
  assign idx      = exec_req.addr[2 +: AW];
  assign arm      = pend;
  assign due_time = pend_req.timestamp;

  // ----------------------------------------------------------
  // registers and response
  // ----------------------------------------------------------

  always_ff @(posedge m_ctrlport_clk) begin
    if (m_rst) begin
      for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
      m_resp.ack <= 1'b0;
      pend       <= 1'b0;
    end else begin
      m_resp.ack <= 1'b0;  // one-cycle strobe
      if (fire) pend <= 1'b0;
      else if (strobe & ~reject & early) pend <= 1'b1;  // hold until due
      if (exec_now) begin
        m_resp.ack    <= 1'b1;
        m_resp.status <= sts_okay;
        if (exec_req.wr) begin
          for (int b = 0; b < 4; b++) begin
            if (exec_req.byte_en[b]) regs[idx][8*b +: 8] <= exec_req.data[8*b +: 8];
          end
          m_resp.data <= '0;  // writes return zero
        end else begin
          m_resp.data <= regs[idx];
        end
      end else if (reject) begin
        m_resp.ack    <= 1'b1;
        m_resp.status <= rej_status;
        m_resp.data   <= '0;
      end
    end
  end

  always_ff @(posedge m_ctrlport_clk) begin
    if (strobe & ~reject & early) pend_req <= m_req;
  end

endmodule

// ==== design/ctrlport_timekeeper.sv ====
// endpoint time counter with a one-shot due flag for held timed requests
`timescale 1ns/1ps

module ctrlport_timekeeper (
  input  logic                        m_ctrlport_clk,
  input  logic                        m_rst,
  input  logic                        arm,       // a timed request is waiting
  input  ctrlport_pkg::ctrlport_time_t due_time,
  output ctrlport_pkg::ctrlport_time_t time_now,
  output logic                        due        // one cycle per arming
);

  logic fired;  // due already given for the current arming

  always_ff @(posedge m_ctrlport_clk) begin
    if (m_rst) begin
      time_now <= '0;
      due      <= 1'b0;
      fired    <= 1'b0;
    end else begin
      time_now <= time_now + 64'd1;  // free running, wrap is far off
      due      <= 1'b0;
      if (!arm) begin
        fired <= 1'b0;  // disarm cancels anything pending
      end else if (!fired && time_now >= due_time) begin
        due   <= 1'b1;
        fired <= 1'b1;
      end
    end
  end

endmodule

// ==== design/handshake.sv ====
// four-phase req/ack crossing of one data word, valid pulse on the destination side
`timescale 1ns/1ps

module handshake #(
  parameter int WIDTH       = 32,
  parameter int SYNC_STAGES = 2
) (
  // source domain
  input  logic             clk_a,
  input  logic             rst_a,
  input  logic             valid_a,
  input  logic [WIDTH-1:0] data_a,
  output logic             busy_a,
  // destination domain
  input  logic             clk_b,
  output logic             valid_b,
  output logic [WIDTH-1:0] data_b
);

  typedef enum logic [1:0] {
    st_idle,
    st_wait_ack_high,
    st_wait_ack_low
  } state_t;

  state_t                 state;
  logic                   req_a;       // level request, glitch free from a flop
  logic [WIDTH-1:0]       data_hold;   // word held stable during the crossing
  logic [SYNC_STAGES-1:0] ack_sync_a;
  logic                   ack_a;
  logic [SYNC_STAGES-1:0] rst_sync_b;
  logic [SYNC_STAGES-1:0] req_sync_b;
  logic                   rst_b;
  logic                   req_b;
  logic                   ack_b;

  // ----------------------------------------------------------
  // source side
  // ----------------------------------------------------------

  always_ff @(posedge clk_a) begin
    if (rst_a) begin
      state <= st_idle;
      req_a <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (valid_a) begin  // capture and raise req
            req_a <= 1'b1;
            state <= st_wait_ack_high;
          end
        end
        st_wait_ack_high: begin
          if (ack_a) begin  // far side has the word
            req_a <= 1'b0;
            state <= st_wait_ack_low;
          end
        end
        st_wait_ack_low: begin
          if (!ack_a) state <= st_idle;  // four phases done
        end
        default: state <= st_idle;
      endcase
    end
  end

  // data only loads when idle, so it stays put until ack returns low
  always_ff @(posedge clk_a) begin
    if (state == st_idle && valid_a) data_hold <= data_a;
  end

  always_ff @(posedge clk_a) ack_sync_a <= {ack_sync_a[SYNC_STAGES-2:0], ack_b};

  assign ack_a  = ack_sync_a[SYNC_STAGES-1];
  assign busy_a = (state != st_idle);  // a new valid_a is ignored while busy

  // ----------------------------------------------------------
  // destination side
  // ----------------------------------------------------------

  always_ff @(posedge clk_b) begin
    rst_sync_b <= {rst_sync_b[SYNC_STAGES-2:0], rst_a};  // reset follows source
    req_sync_b <= {req_sync_b[SYNC_STAGES-2:0], req_a};
  end

  assign rst_b = rst_sync_b[SYNC_STAGES-1];
  assign req_b = req_sync_b[SYNC_STAGES-1];

  // ack_b trails req_b by one cycle, so req_b & ~ack_b is the rising edge
  always_ff @(posedge clk_b) begin
    if (rst_b) begin
      valid_b <= 1'b0;
      ack_b   <= 1'b0;
    end else begin
      valid_b <= req_b & ~ack_b;  // one-cycle pulse
      ack_b   <= req_b;           // drops once req is seen low
    end
  end

  always_ff @(posedge clk_b) begin
    if (req_b & ~ack_b) data_b <= data_hold;  // word is settled by now
  end

endmodule

// ==== tb/tb_ctrlport_cdc.sv ====
// directed testbench for the control-port clock crossing and its endpoint register bank
`timescale 1ns/1ps

module tb_ctrlport_cdc;
  import ctrlport_pkg::*;

  localparam int NUM_REGS      = 16;
  localparam int SYNC_STAGES   = 2;
  localparam int ACK_TIMEOUT   = 200;  // s cycles per request
  localparam int TIMED_TIMEOUT = 600;  // 200 m cycles of hold plus the crossing
  localparam int REQ_GAP       = 8;    // s cycles for the request crossing to finish its four phases

  logic           reset          = 1'b1;
  logic           s_ctrlport_clk = 1'b0;
  logic           m_ctrlport_clk = 1'b0;
  ctrlport_req_t  s_req          = '0;
  ctrlport_resp_t s_resp;
  ctrlport_time_t m_time_now;

  logic [31:0] model [NUM_REGS];  // expected register contents
  int          seed        = 32'hfb65205f;
  int          test_errors = 0;
  int          n_pass      = 0;
  int          n_fail      = 0;

  always #50 s_ctrlport_clk = ~s_ctrlport_clk;  // 100 ns
  always #70 m_ctrlport_clk = ~m_ctrlport_clk;  // 140 ns, unrelated

  ctrlport_cdc_top #(.SYNC_STAGES(SYNC_STAGES), .NUM_REGS(NUM_REGS)) ctrlport_cdc_top_inst (
    .reset         (reset),
    .s_ctrlport_clk(s_ctrlport_clk),
    .m_ctrlport_clk(m_ctrlport_clk),
    .s_req         (s_req),
    .s_resp        (s_resp),
    .m_time_now    (m_time_now)
  );

  // ----------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------

  task automatic compare_status(input string name, input ctrlport_status_t exp,
                                input ctrlport_status_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected status %0d, actual %0d", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic compare_data(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAILED %s: expected data %08h, actual %08h", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic compare_time_at_least(input string name, input ctrlport_time_t exp,
                                       input ctrlport_time_t act);
    if ($isunknown(act) || act < exp) begin
      $display("FAILED %s: expected time at least %0d, actual %0d", name, exp, act);
      test_errors++;
    end
  endtask

  // ----------------------------------------------------------
  // request helpers
  // ----------------------------------------------------------

  function automatic ctrlport_req_t make_req(input logic wr, input logic rd, input int word,
                                             input logic [31:0] data, input logic [3:0] be);
    ctrlport_req_t r;
    r         = '0;
    r.wr      = wr;
    r.rd      = rd;
    r.addr    = 20'(word * 4);  // word index to byte address
    r.data    = data;
    r.byte_en = be;
    return r;
  endfunction

  // idle gap, one-cycle strobe, then poll for the single-cycle ack
  task automatic transact(input string name, input ctrlport_req_t req, input int max_cycles,
                          output ctrlport_resp_t resp);
    int n;
    bit got;
    n    = 0;
    got  = 1'b0;
    resp = '0;
    repeat (REQ_GAP) @(posedge s_ctrlport_clk);
    #5;
    s_req = req;
    @(posedge s_ctrlport_clk);
    #5;
    s_req = '0;
    while (!got && n < max_cycles) begin
      @(posedge s_ctrlport_clk);
      #5;  // ack is held for the whole cycle
      n++;
      if (s_resp.ack) begin
        resp = s_resp;
        got  = 1'b1;
      end
    end
    if (!got) begin
      $display("%s: no response arrived within %0d cycles of the request", name, max_cycles);
      test_errors++;
    end
  endtask

  task automatic write_check(input string name, input int word, input logic [31:0] data,
                             input logic [3:0] be);
    ctrlport_resp_t resp;
    transact(name, make_req(1'b1, 1'b0, word, data, be), ACK_TIMEOUT, resp);
    compare_status(name, sts_okay, resp.status);
    compare_data(name, 32'h0, resp.data);  // writes answer zero
    for (int b = 0; b < 4; b++) begin
      if (be[b]) model[word][8*b +: 8] = data[8*b +: 8];
    end
  endtask

  task automatic read_check(input string name, input int word);
    ctrlport_resp_t resp;
    transact(name, make_req(1'b0, 1'b1, word, 32'h0, 4'h0), ACK_TIMEOUT, resp);
    compare_status(name, sts_okay, resp.status);
    compare_data(name, model[word], resp.data);
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      $display("test %s: passed", name);
      n_pass++;
    end else begin
      $display("test %s: failed with %0d errors", name, test_errors);
      n_fail++;
    end
    test_errors = 0;
  endtask

  // ----------------------------------------------------------
  // tests
  // ----------------------------------------------------------

  task automatic test_reset_state();
    repeat (20) begin
      @(posedge s_ctrlport_clk);
      #5;
      if (s_resp.ack !== 1'b0) begin
        $display("reset_state: s_resp.ack is not low with no request issued");
        test_errors++;
      end
    end
    for (int w = 0; w < NUM_REGS; w++) read_check("reset_state", w);
    finish_test("reset_state");
  endtask

  task automatic test_write_read();
    int          word;
    logic [31:0] data;
    for (int i = 0; i < 32; i++) begin
      word = $unsigned($random(seed)) % NUM_REGS;
      data = $random(seed);
      write_check("write_read", word, data, 4'hf);
      read_check("write_read", word);
    end
    finish_test("write_read");
  endtask

  task automatic test_byte_enables();
    logic [3:0] patterns [9] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h5, 4'ha, 4'h3, 4'hc, 4'h0};
    foreach (patterns[p]) begin
      write_check("byte_enables", 5, $random(seed), patterns[p]);  // model merges bytes
      read_check("byte_enables", 5);
    end
    finish_test("byte_enables");
  endtask

  task automatic test_cmd_errors();
    ctrlport_resp_t resp;
    transact("cmd_errors", make_req(1'b0, 1'b1, NUM_REGS, 32'h0, 4'h0), ACK_TIMEOUT, resp);
    compare_status("cmd_errors", sts_cmderr, resp.status);
    compare_data("cmd_errors", 32'h0, resp.data);
    transact("cmd_errors", make_req(1'b1, 1'b0, NUM_REGS + 3, 32'hdeadbeef, 4'hf),
             ACK_TIMEOUT, resp);
    compare_status("cmd_errors", sts_cmderr, resp.status);
    compare_data("cmd_errors", 32'h0, resp.data);
    transact("cmd_errors", make_req(1'b1, 1'b0, 20'hfffff >> 2, 32'h12345678, 4'hf),
             ACK_TIMEOUT, resp);  // top of the address space
    compare_status("cmd_errors", sts_cmderr, resp.status);
    transact("cmd_errors", make_req(1'b1, 1'b1, 2, 32'hcafef00d, 4'hf), ACK_TIMEOUT, resp);
    compare_status("cmd_errors", sts_cmderr, resp.status);
    compare_data("cmd_errors", 32'h0, resp.data);
    for (int w = 0; w < NUM_REGS; w++) read_check("cmd_errors", w);  // nothing changed
    finish_test("cmd_errors");
  endtask

  task automatic test_timed();
    ctrlport_req_t  req;
    ctrlport_resp_t resp;
    ctrlport_time_t t;
    int             n;
    // held write, executes once the counter reaches t
    t             = m_time_now + 64'd200;
    req           = make_req(1'b1, 1'b0, 7, $random(seed), 4'hf);
    req.has_time  = 1'b1;
    req.timestamp = t;
    transact("timed_write", req, TIMED_TIMEOUT, resp);
    compare_status("timed_write", sts_okay, resp.status);
    compare_data("timed_write", 32'h0, resp.data);
    compare_time_at_least("timed_write", t, m_time_now);
    model[7] = req.data;
    read_check("timed_write", 7);
    // late write, time zero long gone
    n = 0;
    while (m_time_now <= 64'd1000 && n < 2000) begin
      @(posedge s_ctrlport_clk);
      #5;
      n++;
    end
    if (m_time_now <= 64'd1000) begin
      $display("timed_late: endpoint time never passed 1000");
      test_errors++;
    end
    req           = make_req(1'b1, 1'b0, 7, ~model[7], 4'hf);
    req.has_time  = 1'b1;
    req.timestamp = '0;
    transact("timed_late", req, ACK_TIMEOUT, resp);
    compare_status("timed_late", sts_tserr, resp.status);
    compare_data("timed_late", 32'h0, resp.data);
    read_check("timed_late", 7);  // old value kept
    finish_test("timed");
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin
    foreach (model[w]) model[w] = 32'h0;
    repeat (16) @(posedge s_ctrlport_clk);
    #5;
    reset = 1'b0;
    test_reset_state();
    test_write_read();
    test_byte_enables();
    test_cmd_errors();
    test_timed();
    $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
